// ==== Makefile ====
# Verilator build and run of the I3C command path testbench

VERILATOR  ?= verilator
TOP        ?= tb_i3c_ctrl
RTL_TOP    ?= i3c_ctrl_top
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_ARGS   ?= +verilator+error+limit+100
PASS_TEXT  ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== include/i3c_ctrl_defines.svh ====
/* Table depth and host register offsets. DAT_BASE must stay aligned to the
   table span, since the DAT index is taken straight from address bits */
`ifndef I3C_CTRL_DEFINES_SVH
`define I3C_CTRL_DEFINES_SVH

// Device Address Table entries
`define DAT_DEPTH 16

// Byte offsets on the Wishbone register port
`define CSR_CMD_LO   8'h00
`define CSR_CMD_HI   8'h04
`define CSR_RESP     8'h08
`define CSR_STATUS   8'h0C
`define CSR_CONTROL  8'h10
`define CSR_DAT_BASE 8'h40

`endif

// ==== list.f ====
+incdir+include
verilog/i3c_ctrl_pkg.sv
verilog/hci_queue.sv
verilog/dat_table.sv
verilog/hci_csr_wb.sv
verilog/flow_active.sv
verilog/i3c_ctrl_top.sv
tb/i3c_ctrl_assert.sv
tb/tb_i3c_ctrl.sv

// ==== tb/i3c_ctrl_assert.sv ====
/* Port protocol checks on the top level, bound in by the testbench.
   All checks are off while rst_ni is low */
`timescale 1ns/1ps
`default_nettype none

module i3c_ctrl_assert (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       wb_cyc_i,
  input logic       wb_stb_i,
  input logic       wb_ack_o,
  input logic       fmt_valid_o,
  input logic       fmt_ready_i,
  input logic [7:0] fmt_byte_o,
  input logic       fmt_start_o,
  input logic       fmt_stop_o
);

  int unsigned ack_fails = 0;
  int unsigned hold_fails = 0;
  int unsigned start_fails = 0;

  // Ack only inside a request
  ack_in_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_ack_o |-> (wb_cyc_i && wb_stb_i))
  else begin
    $error("wb_ack_o high without cyc and stb");
    ack_fails++;
  end

  // Byte and flags held under back-pressure
  fmt_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fmt_valid_o && !fmt_ready_i) |=> (fmt_valid_o && $stable(fmt_byte_o) &&
                                       $stable(fmt_start_o) && $stable(fmt_stop_o)))
  else begin
    $error("format byte changed while stalled");
    hold_fails++;
  end

  // Start flag only on a valid byte that opens a transfer
  start_with_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fmt_start_o |-> (fmt_valid_o && !$past(fmt_valid_o && fmt_ready_i)))
  else begin
    $error("fmt_start_o without fmt_valid_o or right after an accepted byte");
    start_fails++;
  end

endmodule

`default_nettype wire

// ==== tb/tb_i3c_ctrl.sv ====
/* Table-driven test of the command path; rows go in batches of the command
   queue depth, each row uses its own DAT index */
`timescale 1ns/1ps
`default_nettype none

`include "i3c_ctrl_defines.svh"

module tb_i3c_ctrl
  import i3c_ctrl_pkg::*;
();

  typedef struct packed {
    logic [3:0]  idx;
    logic [31:0] dat;
    logic [2:0]  attr;
    logic [2:0]  dtt;
    logic        toc;
    logic [3:0]  tid;
    logic [31:0] data;
  } row_t;

  localparam int NumRows = 12;
  localparam int CycleLimit = NumRows * 200;

  // idx, DAT entry, attr, DTT, TOC, TID, data bytes 4..1
  localparam row_t Rows [NumRows] = '{
    '{4'd0,  32'h8000_0050, 3'd1, 3'd1, 1'b1, 4'd1,  32'h4433_2211},
    '{4'd1,  32'h8000_0021, 3'd1, 3'd2, 1'b0, 4'd2,  32'hddcc_bbaa},
    '{4'd2,  32'h8000_007f, 3'd1, 3'd3, 1'b1, 4'd3,  32'h0f1e_2d3c},
    '{4'd3,  32'h8000_0001, 3'd1, 3'd4, 1'b1, 4'd4,  32'ha5b6_c7d8},
    '{4'd4,  32'h8000_0042, 3'd1, 3'd5, 1'b1, 4'd5,  32'h1234_5678},
    '{4'd5,  32'h8000_0013, 3'd1, 3'd6, 1'b1, 4'd6,  32'h9abc_def0},
    '{4'd6,  32'h8000_0068, 3'd1, 3'd7, 1'b0, 4'd7,  32'h0bad_cafe},
    '{4'd7,  32'h0000_0030, 3'd1, 3'd2, 1'b1, 4'd8,  32'h5566_7788},
    '{4'd8,  32'h8000_0011, 3'd0, 3'd3, 1'b1, 4'd9,  32'h0102_0304},
    '{4'd9,  32'h8000_0055, 3'd3, 3'd1, 1'b1, 4'd10, 32'h0a0b_0c0d},
    '{4'd10, 32'h8000_0077, 3'd1, 3'd0, 1'b1, 4'd11, 32'hffee_ddcc},
    '{4'd15, 32'h8000_003c, 3'd1, 3'd4, 1'b1, 4'd0,  32'h8877_6655}
  };

  logic        clk_i, rst_ni;
  logic        wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
  logic [7:0]  wb_adr_i;
  logic [31:0] wb_dat_i, wb_dat_o;
  logic        fmt_valid_o, fmt_ready_i, fmt_start_o, fmt_stop_o;
  logic [7:0]  fmt_byte_o;

  int          seed = 85;
  int          errs = 0;
  int          cycles = 0;
  // {stop, start, byte}
  logic [9:0]  got_q [$];
  logic [9:0]  exp_q [$];

  i3c_ctrl_top dut0 (.*);

  bind i3c_ctrl_top i3c_ctrl_assert assert0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Random sink back-pressure
  always @(posedge clk_i) begin
    #1;
    fmt_ready_i = (($random(seed) & 3) != 0);
  end

  // Handshake is stable at the falling edge
  always @(negedge clk_i) begin
    if (rst_ni && fmt_valid_o && fmt_ready_i) begin
      got_q.push_back({fmt_stop_o, fmt_start_o, fmt_byte_o});
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= CycleLimit) begin
      $display("Timeout: run not finished after %0d cycles, %0d errors", cycles, errs);
      $display("Regression failed");
      $finish;
    end
  end

  // Called 1 ns after an edge, returns 1 ns after an edge
  task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int waited;
    waited = 0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdata;
    while (!wb_ack_o && waited < 16) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (!wb_ack_o) begin
      errs++;
      $display("Wishbone access to 0x%0h was never acknowledged", adr);
    end
    rdata = wb_dat_o;
    // Access acts on this edge
    @(posedge clk_i);
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [7:0] adr, output logic [31:0] data);
    wb_access(1'b0, adr, 32'h0, data);
  endtask

  task automatic push_cmd(input row_t r);
    logic [31:0] lo;
    lo = '0;
    lo[2:0]   = r.attr;
    lo[6:3]   = r.tid;
    lo[20:16] = {1'b0, r.idx};
    lo[25:23] = r.dtt;
    lo[31]    = r.toc;
    wb_write(`CSR_CMD_LO, lo);
    wb_write(`CSR_CMD_HI, r.data);
  endtask

  function automatic logic is_supported(input row_t r);
    return (r.attr == ImmediateDataTransfer) && r.dat[31];
  endfunction

  // Address byte, then payload; DTT 5..7 skip data byte 1
  task automatic add_expected(input row_t r);
    int n;
    int first;
    if (r.dtt > 3'd4) begin
      n = int'(r.dtt) - 5;
      first = 1;
    end else begin
      n = int'(r.dtt);
      first = 0;
    end
    exp_q.push_back({r.toc && n == 0, 1'b1, r.dat[6:0], 1'b0});
    for (int i = 0; i < n; i++) begin
      exp_q.push_back({r.toc && i == n - 1, 1'b0, r.data[8 * (first + i) +: 8]});
    end
  endtask

  task automatic check_status(input logic [2:0] level, input logic empty, input logic idle,
                              input logic ovf);
    logic [31:0] want;
    logic [31:0] got;
    want = {23'h0, ovf, 2'b00, idle, empty, 1'b0, level};
    wb_read(`CSR_STATUS, got);
    if (got !== want) begin
      errs++;
      $display("ERR STATUS got 0x%08h expected 0x%08h", got, want);
    end
  endtask

  task automatic wait_resp();
    logic [31:0] st;
    st = 32'h10;
    while (st[4]) begin
      wb_read(`CSR_STATUS, st);
    end
  endtask

  task automatic compare_bytes();
    logic [9:0] got;
    logic [9:0] want;
    if (got_q.size() != exp_q.size()) begin
      errs++;
      $display("Format sink took %0d bytes, %0d expected", got_q.size(), exp_q.size());
    end
    while (got_q.size() > 0 && exp_q.size() > 0) begin
      got = got_q.pop_front();
      want = exp_q.pop_front();
      if (got[7:0] !== want[7:0]) begin
        errs++;
        $display("ERR fmt_byte_o got 0x%02h expected 0x%02h", got[7:0], want[7:0]);
      end
      if (got[8] !== want[8]) begin
        errs++;
        $display("ERR fmt_start_o got 0x%0h expected 0x%0h", got[8], want[8]);
      end
      if (got[9] !== want[9]) begin
        errs++;
        $display("ERR fmt_stop_o got 0x%0h expected 0x%0h", got[9], want[9]);
      end
    end
    got_q.delete();
    exp_q.delete();
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] want;
    int          afails;
    rst_ni = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    fmt_ready_i = 1'b0;
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;
    check_status(3'd0, 1'b1, 1'b1, 1'b0);
    for (int i = 0; i < NumRows; i++) begin
      wb_write(`CSR_DAT_BASE + 8'(4 * Rows[i].idx), Rows[i].dat);
    end
    for (int b = 0; b < NumRows; b += CmdFifoDepth) begin
      for (int i = b; i < b + CmdFifoDepth; i++) begin
        push_cmd(Rows[i]);
        if (is_supported(Rows[i])) begin
          add_expected(Rows[i]);
        end
      end
      // First batch waits in the queue, then one push too many
      if (b == 0) begin
        check_status(3'd4, 1'b1, 1'b1, 1'b0);
        push_cmd(Rows[0]);
        check_status(3'd4, 1'b1, 1'b1, 1'b1);
        wb_write(`CSR_CONTROL, 32'h1);
      end
      for (int i = b; i < b + CmdFifoDepth; i++) begin
        wait_resp();
        wb_read(`CSR_RESP, rd);
        want = {is_supported(Rows[i]) ? 4'(Success) : 4'(NotSupported), Rows[i].tid, 24'h0};
        if (rd !== want) begin
          errs++;
          $display("ERR RESP row %0d got 0x%08h expected 0x%08h", i, rd, want);
        end
      end
      compare_bytes();
    end
    // Engine back waiting for commands
    check_status(3'd0, 1'b1, 1'b0, 1'b1);
    wb_read(`CSR_RESP, rd);
    if (rd !== 32'h0) begin
      errs++;
      $display("ERR RESP empty read got 0x%08h expected 0x00000000", rd);
    end
    afails = dut0.assert0.ack_fails + dut0.assert0.hold_fails + dut0.assert0.start_fails;
    $display("Check errors: %0d, assertion failures: %0d", errs, afails);
    if (errs == 0 && afails == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/dat_table.sv ====
/* Device Address Table, cleared at reset. Read data shows up one cycle
   after rd_valid_i and holds until the next read */
`timescale 1ns/1ps
`default_nettype none

module dat_table
  import i3c_ctrl_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     wr_en_i,
  input  logic [DatIndexWidth-1:0] wr_index_i,
  input  logic [DatEntryWidth-1:0] wr_data_i,
  input  logic                     rd_valid_i,
  input  logic [DatIndexWidth-1:0] rd_index_i,
  output logic [DatEntryWidth-1:0] rd_data_o
);

  logic [DatEntryWidth-1:0] entries [`DAT_DEPTH];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `DAT_DEPTH; i++) begin
        entries[i] <= '0;
      end
      rd_data_o <= '0;
    end else begin
      // Host writes land directly
      if (wr_en_i) begin
        entries[wr_index_i] <= wr_data_i;
      end
      // Registered read port
      if (rd_valid_i) begin
        rd_data_o <= entries[rd_index_i];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/flow_active.sv ====
/* Command flow engine. Runs immediate writes to legacy I2C devices only;
   anything else gets NotSupported. Response length is always zero */
`timescale 1ns/1ps
`default_nettype none

module flow_active
  import i3c_ctrl_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Command queue
  input  logic                     cmd_queue_rvalid_i,
  output logic                     cmd_queue_rready_o,
  input  logic [CmdFifoWidth-1:0]  cmd_queue_rdata_i,
  // Response queue
  output logic                     resp_queue_wvalid_o,
  input  logic                     resp_queue_wready_i,
  output logic [RespFifoWidth-1:0] resp_queue_wdata_o,
  // DAT read
  output logic                     dat_read_valid_o,
  output logic [DatIndexWidth-1:0] dat_index_o,
  input  logic [DatEntryWidth-1:0] dat_rdata_i,
  // I2C format sink
  output logic                     fmt_valid_o,
  input  logic                     fmt_ready_i,
  output logic [7:0]               fmt_byte_o,
  output logic                     fmt_start_o,
  output logic                     fmt_stop_o,
  // Flow control
  input  logic                     flow_en_i,
  output logic                     flow_idle_o
);

  flow_fsm_state_e state_q, state_d;
  i3c_resp_err_status_e resp_status_q, resp_status_d;
  i3c_cmd_attr_e cmd_attr;

  logic [CmdFifoWidth-1:0]  cmd_desc_q;
  logic [DatEntryWidth-1:0] dat_entry_q;
  logic                     dat_pend_q;
  logic [2:0]               xfer_cnt_q;
  logic [2:0]               dtt, data_length, last_cnt;
  logic                     use_def_byte, supported;
  logic [1:0]               byte_sel;

  // Descriptor fields
  assign cmd_attr    = i3c_cmd_attr_e'(cmd_desc_q[CmdAttrMsb:CmdAttrLsb]);
  assign dtt         = cmd_desc_q[CmdDttMsb:CmdDttLsb];
  assign dat_index_o = cmd_desc_q[CmdDevIdxLsb +: DatIndexWidth];

  // DTT 5 to 7 carry a defining byte, which is dropped
  assign use_def_byte = (dtt > 3'd4);
  assign data_length  = use_def_byte ? dtt - 3'd5 : dtt;
  assign last_cnt     = data_length + 3'(BytesBeforeImmData) - 3'd1;

  // Decided on the cycle the DAT entry is on dat_rdata_i
  assign supported = (cmd_attr == ImmediateDataTransfer) &
                     dat_rdata_i[DatLegacyBit] & ~cmd_desc_q[CmdRnwBit];

  // Payload byte N maps to data byte N, or N+1 past a defining byte
  assign byte_sel = xfer_cnt_q[1:0] - 2'd1 + {1'b0, use_def_byte};

  // Address byte carries a write bit of 0
  assign fmt_byte_o  = (xfer_cnt_q == 3'd0) ?
                       {dat_entry_q[DatAddrMsb:DatAddrLsb], 1'b0} :
                       cmd_desc_q[CmdDataLsb + 8 * byte_sel +: 8];
  assign fmt_start_o = fmt_valid_o & (xfer_cnt_q == 3'd0);
  assign fmt_stop_o  = fmt_valid_o & cmd_desc_q[CmdTocBit] & (xfer_cnt_q == last_cnt);

  always_comb begin
    resp_queue_wdata_o = '0;
    resp_queue_wdata_o[RespStatusMsb:RespStatusLsb] = resp_status_q;
    resp_queue_wdata_o[RespTidMsb:RespTidLsb] = cmd_desc_q[CmdTidMsb:CmdTidLsb];
    // No read data is returned
    resp_queue_wdata_o[RespLenMsb:RespLenLsb] = '0;
  end

  // Next state and strobes
  always_comb begin
    state_d             = state_q;
    resp_status_d       = resp_status_q;
    flow_idle_o         = 1'b0;
    cmd_queue_rready_o  = 1'b0;
    dat_read_valid_o    = 1'b0;
    fmt_valid_o         = 1'b0;
    resp_queue_wvalid_o = 1'b0;
    unique case (state_q)
      Idle: begin
        flow_idle_o = 1'b1;
        if (flow_en_i) begin
          state_d = WaitForCmd;
        end
      end
      WaitForCmd: begin
        cmd_queue_rready_o = 1'b1;
        if (cmd_queue_rvalid_i) begin
          state_d = FetchDAT;
        end
      end
      // Request in the first cycle, entry valid in the second
      FetchDAT: begin
        dat_read_valid_o = ~dat_pend_q;
        if (dat_pend_q) begin
          resp_status_d = supported ? Success : NotSupported;
          state_d = supported ? I2CWriteImmediate : WriteResp;
        end
      end
      // Byte stays put until the sink takes it
      I2CWriteImmediate: begin
        fmt_valid_o = 1'b1;
        if (fmt_ready_i && xfer_cnt_q == last_cnt) begin
          state_d = WriteResp;
        end
      end
      // Stall while the response queue is full
      WriteResp: begin
        resp_queue_wvalid_o = 1'b1;
        if (resp_queue_wready_i) begin
          state_d = Idle;
        end
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= Idle;
      resp_status_q <= Success;
      dat_pend_q    <= 1'b0;
      xfer_cnt_q    <= '0;
    end else begin
      state_q       <= state_d;
      resp_status_q <= resp_status_d;
      dat_pend_q    <= (state_q == FetchDAT) & ~dat_pend_q;
      // Counter runs only during the byte stream
      if (state_q != I2CWriteImmediate) begin
        xfer_cnt_q <= '0;
      end else if (fmt_ready_i) begin
        xfer_cnt_q <= xfer_cnt_q + 3'd1;
      end
    end
  end

  // Descriptor on the pop, DAT entry in the second fetch cycle
  always_ff @(posedge clk_i) begin
    if (cmd_queue_rvalid_i && cmd_queue_rready_o) begin
      cmd_desc_q <= cmd_queue_rdata_i;
    end
    if (state_q == FetchDAT && dat_pend_q) begin
      dat_entry_q <= dat_rdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/hci_csr_wb.sv ====
/* Wishbone classic register port. Ack follows a request by one cycle and
   the access acts in the ack cycle; word offsets only, byte lanes ignored */
`timescale 1ns/1ps
`default_nettype none

`include "i3c_ctrl_defines.svh"

module hci_csr_wb
  import i3c_ctrl_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Wishbone
  input  logic                     wb_cyc_i,
  input  logic                     wb_stb_i,
  input  logic                     wb_we_i,
  input  logic [7:0]               wb_adr_i,
  input  logic [31:0]              wb_dat_i,
  output logic [31:0]              wb_dat_o,
  output logic                     wb_ack_o,
  // Command queue
  output logic                     cmd_wvalid_o,
  input  logic                     cmd_wready_i,
  output logic [CmdFifoWidth-1:0]  cmd_wdata_o,
  input  logic [CmdLevelWidth-1:0] cmd_level_i,
  // Response queue
  input  logic                     resp_rvalid_i,
  output logic                     resp_rready_o,
  input  logic [RespFifoWidth-1:0] resp_rdata_i,
  // DAT host writes
  output logic                     dat_wr_en_o,
  output logic [DatIndexWidth-1:0] dat_wr_index_o,
  output logic [DatEntryWidth-1:0] dat_wr_data_o,
  // Flow engine
  input  logic                     flow_idle_i,
  output logic                     flow_en_o
);

  logic [7:0]  reg_addr;
  logic        access, wr_access, rd_access, dat_hit;
  logic        overflow_q;
  logic [31:0] cmd_lo_q;
  logic [31:0] status;

  assign reg_addr  = {wb_adr_i[7:2], 2'b00};
  assign access    = wb_ack_o & wb_cyc_i & wb_stb_i;
  assign wr_access = access & wb_we_i;
  assign rd_access = access & ~wb_we_i;
  assign dat_hit   = (reg_addr >= `CSR_DAT_BASE) &&
                     (int'(reg_addr) < int'(`CSR_DAT_BASE) + 4 * `DAT_DEPTH);

  // CMD_HI completes the descriptor and pushes it
  assign cmd_wvalid_o = wr_access & (reg_addr == `CSR_CMD_HI);
  assign cmd_wdata_o  = {wb_dat_i, cmd_lo_q};

  // Pop on RESP read; an empty queue has rvalid low, so nothing moves
  assign resp_rready_o = rd_access & (reg_addr == `CSR_RESP);

  // Base is span aligned, so the index sits in the word address bits
  assign dat_wr_en_o    = wr_access & dat_hit;
  assign dat_wr_index_o = reg_addr[2 +: DatIndexWidth];
  assign dat_wr_data_o  = wb_dat_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_ack_o   <= 1'b0;
      flow_en_o  <= 1'b0;
      overflow_q <= 1'b0;
      cmd_lo_q   <= '0;
    end else begin
      // Single-cycle ack per request
      wb_ack_o <= wb_cyc_i & wb_stb_i & ~wb_ack_o;
      if (wr_access && reg_addr == `CSR_CMD_LO) begin
        cmd_lo_q <= wb_dat_i;
      end
      if (wr_access && reg_addr == `CSR_CONTROL) begin
        flow_en_o <= wb_dat_i[0];
      end
      // Sticky, dropped push on a full queue
      if (cmd_wvalid_o && !cmd_wready_i) begin
        overflow_q <= 1'b1;
      end
    end
  end

  always_comb begin
    status = '0;
    status[CmdLevelWidth-1:0] = cmd_level_i;
    status[4] = ~resp_rvalid_i;
    status[5] = flow_idle_i;
    status[8] = overflow_q;
  end

  // Read mux
  always_comb begin
    case (reg_addr)
      `CSR_CMD_LO:  wb_dat_o = cmd_lo_q;
      `CSR_RESP:    wb_dat_o = resp_rvalid_i ? resp_rdata_i : '0;
      `CSR_STATUS:  wb_dat_o = status;
      `CSR_CONTROL: wb_dat_o = {31'b0, flow_en_o};
      default:      wb_dat_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/hci_queue.sv ====
/* Synchronous FIFO with valid/ready ports. Read data is the oldest entry
   and is only meaningful while rvalid_o is high */
`timescale 1ns/1ps
`default_nettype none

module hci_queue #(
  parameter int unsigned Width = 32,
  parameter int unsigned Depth = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         wvalid_i,
  output logic                         wready_o,
  input  logic [Width-1:0]             wdata_i,
  output logic                         rvalid_o,
  input  logic                         rready_i,
  output logic [Width-1:0]             rdata_o,
  output logic [$clog2(Depth+1)-1:0]   level_o,
  output logic                         empty_o,
  output logic                         full_o
);

  logic [Width-1:0]           mem [Depth];
  logic [$clog2(Depth)-1:0]   wptr_q, rptr_q;
  logic                       push, pop;

  assign empty_o  = (level_o == '0);
  assign full_o   = (level_o == Depth);
  assign wready_o = ~full_o;
  assign rvalid_o = ~empty_o;
  assign rdata_o  = mem[rptr_q];

  // One entry moves per handshake on each side
  assign push = wvalid_i & wready_o;
  assign pop  = rvalid_o & rready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      level_o <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == Depth - 1) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == Depth - 1) ? '0 : rptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the level
      if (push && !pop) begin
        level_o <= level_o + 1'b1;
      end else if (pop && !push) begin
        level_o <= level_o - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wptr_q] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/i3c_ctrl_pkg.sv ====
/* Widths, descriptor field positions and enums of the command path.
   Only immediate writes to legacy I2C devices are executed */
`default_nettype none

`include "i3c_ctrl_defines.svh"

package i3c_ctrl_pkg;

  // Descriptor and queue sizes
  localparam int unsigned CmdFifoWidth  = 64;
  localparam int unsigned RespFifoWidth = 32;
  localparam int unsigned CmdFifoDepth  = 4;
  localparam int unsigned RespFifoDepth = 4;
  localparam int unsigned CmdLevelWidth = $clog2(CmdFifoDepth + 1);
  localparam int unsigned DatIndexWidth = $clog2(`DAT_DEPTH);
  localparam int unsigned DatEntryWidth = 32;

  // Address byte sent ahead of the payload
  localparam int unsigned BytesBeforeImmData = 1;

  // Command descriptor fields
  localparam int unsigned CmdAttrLsb   = 0;
  localparam int unsigned CmdAttrMsb   = 2;
  localparam int unsigned CmdTidLsb    = 3;
  localparam int unsigned CmdTidMsb    = 6;
  localparam int unsigned CmdDevIdxLsb = 16;
  localparam int unsigned CmdDttLsb    = 23;
  localparam int unsigned CmdDttMsb    = 25;
  localparam int unsigned CmdRnwBit    = 29;
  localparam int unsigned CmdTocBit    = 31;
  // Data byte 1 starts here, bytes 2 to 4 follow in 8-bit steps
  localparam int unsigned CmdDataLsb   = 32;

  // DAT entry fields
  localparam int unsigned DatAddrLsb   = 0;
  localparam int unsigned DatAddrMsb   = 6;
  localparam int unsigned DatLegacyBit = 31;

  // Response descriptor fields
  localparam int unsigned RespStatusLsb = 28;
  localparam int unsigned RespStatusMsb = 31;
  localparam int unsigned RespTidLsb    = 24;
  localparam int unsigned RespTidMsb    = 27;
  localparam int unsigned RespLenLsb    = 0;
  localparam int unsigned RespLenMsb    = 15;

  typedef enum logic [2:0] {
    RegularTransfer       = 3'd0,
    ImmediateDataTransfer = 3'd1,
    AddressAssignment     = 3'd2,
    ComboTransfer         = 3'd3,
    InternalControl       = 3'd7
  } i3c_cmd_attr_e;

  typedef enum logic [3:0] {
    Success      = 4'd0,
    NotSupported = 4'd12
  } i3c_resp_err_status_e;

  typedef enum logic [2:0] {
    Idle,
    WaitForCmd,
    FetchDAT,
    I2CWriteImmediate,
    WriteResp
  } flow_fsm_state_e;

endpackage

`default_nettype wire

// ==== verilog/i3c_ctrl_top.sv ====
/* Command path of the I3C host controller. Host side is Wishbone classic,
   device side is an I2C format sink with valid/ready */
`timescale 1ns/1ps
`default_nettype none

module i3c_ctrl_top
  import i3c_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  // Wishbone classic slave
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [7:0]  wb_adr_i,
  input  logic [31:0] wb_dat_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  // I2C format sink
  output logic        fmt_valid_o,
  input  logic        fmt_ready_i,
  output logic [7:0]  fmt_byte_o,
  output logic        fmt_start_o,
  output logic        fmt_stop_o
);

  // Command queue
  logic                     cmd_wvalid, cmd_wready, cmd_rvalid, cmd_rready;
  logic [CmdFifoWidth-1:0]  cmd_wdata, cmd_rdata;
  logic [CmdLevelWidth-1:0] cmd_level;
  // Response queue
  logic                     resp_wvalid, resp_wready, resp_rvalid, resp_rready;
  logic [RespFifoWidth-1:0] resp_wdata, resp_rdata;
  // DAT
  logic                     dat_wr_en, dat_rd_valid;
  logic [DatIndexWidth-1:0] dat_wr_index, dat_rd_index;
  logic [DatEntryWidth-1:0] dat_wr_data, dat_rd_data;
  // Flow control
  logic                     flow_idle, flow_en;

  hci_csr_wb csr0 (
    .clk_i, .rst_ni,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
    .cmd_wvalid_o(cmd_wvalid), .cmd_wready_i(cmd_wready),
    .cmd_wdata_o(cmd_wdata), .cmd_level_i(cmd_level),
    .resp_rvalid_i(resp_rvalid), .resp_rready_o(resp_rready), .resp_rdata_i(resp_rdata),
    .dat_wr_en_o(dat_wr_en), .dat_wr_index_o(dat_wr_index), .dat_wr_data_o(dat_wr_data),
    .flow_idle_i(flow_idle), .flow_en_o(flow_en)
  );

  hci_queue #(.Width(CmdFifoWidth), .Depth(CmdFifoDepth)) cmd_queue0 (
    .clk_i, .rst_ni,
    .wvalid_i(cmd_wvalid), .wready_o(cmd_wready), .wdata_i(cmd_wdata),
    .rvalid_o(cmd_rvalid), .rready_i(cmd_rready), .rdata_o(cmd_rdata),
    .level_o(cmd_level), .empty_o(), .full_o()
  );

  hci_queue #(.Width(RespFifoWidth), .Depth(RespFifoDepth)) resp_queue0 (
    .clk_i, .rst_ni,
    .wvalid_i(resp_wvalid), .wready_o(resp_wready), .wdata_i(resp_wdata),
    .rvalid_o(resp_rvalid), .rready_i(resp_rready), .rdata_o(resp_rdata),
    .level_o(), .empty_o(), .full_o()
  );

  dat_table dat0 (
    .clk_i, .rst_ni,
    .wr_en_i(dat_wr_en), .wr_index_i(dat_wr_index), .wr_data_i(dat_wr_data),
    .rd_valid_i(dat_rd_valid), .rd_index_i(dat_rd_index), .rd_data_o(dat_rd_data)
  );

  flow_active flow0 (
    .clk_i, .rst_ni,
    .cmd_queue_rvalid_i(cmd_rvalid), .cmd_queue_rready_o(cmd_rready),
    .cmd_queue_rdata_i(cmd_rdata),
    .resp_queue_wvalid_o(resp_wvalid), .resp_queue_wready_i(resp_wready),
    .resp_queue_wdata_o(resp_wdata),
    .dat_read_valid_o(dat_rd_valid), .dat_index_o(dat_rd_index), .dat_rdata_i(dat_rd_data),
    .fmt_valid_o, .fmt_ready_i, .fmt_byte_o, .fmt_start_o, .fmt_stop_o,
    .flow_en_i(flow_en), .flow_idle_o(flow_idle)
  );

endmodule

`default_nettype wire
